/* decode_stage.f */
decode_pkg.sv
reg_file.sv
inst_decoder.sv
operand_select.sv
decode_handshake.sv
decode_stage.sv
tb_decode_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decode_stage.f \
    --top-module tb_decode_stage -o sim_decode_stage

out=$(./obj_dir/sim_decode_stage || true)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* tb_decode_stage.sv */
`timescale 1ns/1ns

module tb_decode_stage import decode_pkg::*; ();

    localparam int N_TXN       = 43;
    localparam int CYCLE_LIMIT = 12 * N_TXN + 200;

    // instruction forms of the reference decoder
    localparam logic [1:0] F_BAD = 2'd0;
    localparam logic [1:0] F_RR  = 2'd1;
    localparam logic [1:0] F_SH  = 2'd2;
    localparam logic [1:0] F_RI  = 2'd3;

    logic        clk;
    logic        rst;
    logic        req_i;
    word_t       inst_i;
    reg_write_t  ex_fwd_i;
    reg_write_t  mem_fwd_i;
    reg_write_t  wb_i;
    logic        ack_o;
    decode_out_t result_o;

    word_t       model [32]; // register contents as written through wb_i
    decode_out_t exp_q [$];
    decode_out_t held;
    logic        ack_seen;
    int          errors;
    int          txn_count;
    int          cycles;

    func_e   rr_funcs [13] = '{FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR, FUNC_SLLV, FUNC_SRLV,
                               FUNC_SRAV, FUNC_ADD, FUNC_ADDU, FUNC_SUB, FUNC_SUBU, FUNC_SLT,
                               FUNC_SLTU};
    opcode_e imm_ops [8]   = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI,
                               OP_SLTIU};
    func_e   sh_funcs [3]  = '{FUNC_SLL, FUNC_SRL, FUNC_SRA};

    decode_stage u_dut (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req_i),
        .inst_i    (inst_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_i      (wb_i),
        .ack_o     (ack_o),
        .result_o  (result_o)
    );

    always #2 clk = ~clk;

    function automatic reg_addr_t rand_addr();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    function automatic word_t rtype_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                         logic [4:0] sa, func_e fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype_word(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t forwarded_value(reg_addr_t addr, word_t regval,
                                              reg_write_t ex, reg_write_t mem);
        if (ex.wreg && ex.wd == addr && addr != '0) return ex.wdata; // ex is younger
        if (mem.wreg && mem.wd == addr && addr != '0) return mem.wdata;
        return regval;
    endfunction

    function automatic decode_out_t expected_decode(word_t inst, word_t regs [32],
                                                    reg_write_t ex, reg_write_t mem);
        decode_out_t e;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        logic [7:0]  op_x;
        logic [2:0]  sel_x;
        logic [1:0]  form;
        word_t       imm;
        word_t       zext;
        word_t       sext;
        word_t       upper;
        logic        sa_ok;
        logic        rs_ok;
        rs    = inst[25:21];
        rt    = inst[20:16];
        rd    = inst[15:11];
        sa    = inst[10:6];
        sa_ok = (sa == '0);
        rs_ok = (rs == '0);
        zext  = {16'h0000, inst[15:0]};
        sext  = {{16{inst[15]}}, inst[15:0]};
        upper = {inst[15:0], 16'h0000};
        op_x  = ALU_NOP;
        sel_x = SEL_NOP;
        form  = F_BAD;
        imm   = '0;
        if (inst[31:26] == OP_SPECIAL) begin
            case (inst[5:0])
                FUNC_AND:  {op_x, sel_x, form} = {ALU_AND, SEL_LOGIC, sa_ok ? F_RR : F_BAD};
                FUNC_OR:   {op_x, sel_x, form} = {ALU_OR,  SEL_LOGIC, sa_ok ? F_RR : F_BAD};
                FUNC_XOR:  {op_x, sel_x, form} = {ALU_XOR, SEL_LOGIC, sa_ok ? F_RR : F_BAD};
                FUNC_NOR:  {op_x, sel_x, form} = {ALU_NOR, SEL_LOGIC, sa_ok ? F_RR : F_BAD};
                FUNC_SLLV: {op_x, sel_x, form} = {ALU_SLL, SEL_SHIFT, sa_ok ? F_RR : F_BAD};
                FUNC_SRLV: {op_x, sel_x, form} = {ALU_SRL, SEL_SHIFT, sa_ok ? F_RR : F_BAD};
                FUNC_SRAV: {op_x, sel_x, form} = {ALU_SRA, SEL_SHIFT, sa_ok ? F_RR : F_BAD};
                FUNC_SLL:  {op_x, sel_x, form} = {ALU_SLL, SEL_SHIFT, rs_ok ? F_SH : F_BAD};
                FUNC_SRL:  {op_x, sel_x, form} = {ALU_SRL, SEL_SHIFT, rs_ok ? F_SH : F_BAD};
                FUNC_SRA:  {op_x, sel_x, form} = {ALU_SRA, SEL_SHIFT, rs_ok ? F_SH : F_BAD};
                FUNC_ADD:  {op_x, sel_x, form} = {ALU_ADD,  SEL_ARITH, F_RR};
                FUNC_ADDU: {op_x, sel_x, form} = {ALU_ADDU, SEL_ARITH, F_RR};
                FUNC_SUB:  {op_x, sel_x, form} = {ALU_SUB,  SEL_ARITH, F_RR};
                FUNC_SUBU: {op_x, sel_x, form} = {ALU_SUBU, SEL_ARITH, F_RR};
                FUNC_SLT:  {op_x, sel_x, form} = {ALU_SLT,  SEL_ARITH, F_RR};
                FUNC_SLTU: {op_x, sel_x, form} = {ALU_SLTU, SEL_ARITH, F_RR};
                default: ;
            endcase
        end else begin
            case (inst[31:26])
                OP_ANDI:  {op_x, sel_x, form, imm} = {ALU_ANDI,  SEL_LOGIC, F_RI, zext};
                OP_ORI:   {op_x, sel_x, form, imm} = {ALU_ORI,   SEL_LOGIC, F_RI, zext};
                OP_XORI:  {op_x, sel_x, form, imm} = {ALU_XORI,  SEL_LOGIC, F_RI, zext};
                OP_LUI:   {op_x, sel_x, form, imm} = {ALU_LUI,   SEL_LOGIC, F_RI, upper};
                OP_ADDI:  {op_x, sel_x, form, imm} = {ALU_ADDI,  SEL_ARITH, F_RI, sext};
                OP_ADDIU: {op_x, sel_x, form, imm} = {ALU_ADDIU, SEL_ARITH, F_RI, sext};
                OP_SLTI:  {op_x, sel_x, form, imm} = {ALU_SLTI,  SEL_ARITH, F_RI, sext};
                OP_SLTIU: {op_x, sel_x, form, imm} = {ALU_SLTIU, SEL_ARITH, F_RI, sext};
                default: ;
            endcase
        end
        if (form == F_SH) imm = {27'd0, sa}; // shift amount rides as immediate
        e    = '0;
        e.wd = (form == F_RI) ? rt : rd;
        if (form != F_BAD) begin
            e.aluop      = alu_op_e'(op_x);
            e.alusel     = alu_sel_e'(sel_x);
            e.wreg       = 1'b1;
            e.inst_valid = 1'b1;
        end else begin
            e.aluop  = ALU_NOP;
            e.alusel = SEL_NOP;
        end
        e.reg1 = (form == F_RR || form == F_RI) ? forwarded_value(rs, regs[rs], ex, mem) : imm;
        e.reg2 = (form == F_RR || form == F_SH) ? forwarded_value(rt, regs[rt], ex, mem) : imm;
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        $display("ERROR t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    task automatic compare_result(input decode_out_t e, input decode_out_t r);
        if (r.aluop !== e.aluop)
            report_mismatch("result_o.aluop", 128'(e.aluop), 128'(r.aluop));
        if (r.alusel !== e.alusel)
            report_mismatch("result_o.alusel", 128'(e.alusel), 128'(r.alusel));
        if (r.wd !== e.wd)
            report_mismatch("result_o.wd", 128'(e.wd), 128'(r.wd));
        if (r.wreg !== e.wreg)
            report_mismatch("result_o.wreg", 128'(e.wreg), 128'(r.wreg));
        if (r.inst_valid !== e.inst_valid)
            report_mismatch("result_o.inst_valid", 128'(e.inst_valid), 128'(r.inst_valid));
        if (r.reg1 !== e.reg1)
            report_mismatch("result_o.reg1", 128'(e.reg1), 128'(r.reg1));
        if (r.reg2 !== e.reg2)
            report_mismatch("result_o.reg2", 128'(e.reg2), 128'(r.reg2));
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        wb_i <= {1'b1, addr, data};
        @(posedge clk);
        wb_i <= '0;
        if (addr != '0) model[addr] = data;
    endtask

    // one four-phase transaction, req held for extra cycles after ack
    task automatic run_txn(input word_t inst, input reg_write_t ex, input reg_write_t mem,
                           input int hold);
        int n;
        @(posedge clk);
        exp_q.push_back(expected_decode(inst, model, ex, mem));
        req_i     <= 1'b1;
        inst_i    <= inst;
        ex_fwd_i  <= ex;
        mem_fwd_i <= mem;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack_o && n < 8);
        if (!ack_o) begin
            $display("no ack for instruction %h within %0d cycles", inst, n);
            errors++;
        end else if (n != 2) begin
            $display("ack for instruction %h came after %0d cycles instead of 2", inst, n);
            errors++;
        end
        repeat (hold) begin
            @(posedge clk);
            inst_i <= ~inst; // new word under back-pressure must not be decoded
        end
        @(posedge clk);
        req_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (ack_o && n < 8);
        if (ack_o) begin
            $display("ack stayed high after req dropped for instruction %h", inst);
            errors++;
        end else if (n != 2) begin
            $display("ack fell %0d cycles after req dropped instead of 2", n);
            errors++;
        end
        txn_count++;
    endtask

    // compare on ack rising, then watch the result while ack stays high
    always @(negedge clk) begin
        if (ack_o && !ack_seen) begin
            if (exp_q.size() == 0) begin
                $display("ack rose with no request outstanding");
                errors++;
            end else begin
                compare_result(exp_q.pop_front(), result_o);
            end
            held = result_o;
        end else if (ack_o && result_o !== held) begin
            report_mismatch("result_o (held)", 128'(held), 128'(result_o));
        end
        ack_seen = ack_o;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the transactions did not finish", cycles);
            $display("errors: %0d  transactions: %0d", errors, txn_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] imm16;
        reg_addr_t   rs;
        word_t       v;
        void'($urandom(45));
        clk       = 1'b0;
        rst       = 1'b1;
        req_i     = 1'b0;
        inst_i    = '0;
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        wb_i      = '0;
        ack_seen  = 1'b0;
        errors    = 0;
        txn_count = 0;
        cycles    = 0;
        for (int i = 0; i < 32; i++) model[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (ack_o !== 1'b0) report_mismatch("ack_o", 128'(1'b0), 128'(ack_o));
        if (result_o !== '0) report_mismatch("result_o", 128'(0), 128'(result_o));

        run_txn(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, FUNC_OR), '0, '0, 0); // regs still zero
        for (int i = 1; i < 32; i++) write_reg(reg_addr_t'(i), $urandom());

        foreach (rr_funcs[k])
            run_txn(rtype_word(rand_addr(), rand_addr(), rand_addr(), 5'd0, rr_funcs[k]),
                    '0, '0, 0);

        foreach (imm_ops[k]) begin
            imm16 = 16'($urandom());
            run_txn(itype_word(imm_ops[k], rand_addr(), rand_addr(), imm16 | 16'h8000),
                    '0, '0, 0);
            run_txn(itype_word(imm_ops[k], rand_addr(), rand_addr(), imm16 & 16'h7fff),
                    '0, '0, 0);
        end
        foreach (sh_funcs[k])
            run_txn(rtype_word(5'd0, rand_addr(), rand_addr(), rand_addr(), sh_funcs[k]),
                    '0, '0, 0);

        // invalid encodings
        run_txn({6'h23, rand_addr(), rand_addr(), 16'h0010}, '0, '0, 0);
        run_txn(rtype_word(5'd1, 5'd2, 5'd3, 5'd3, FUNC_AND), '0, '0, 0);
        run_txn(rtype_word(5'd4, 5'd2, 5'd3, 5'd2, FUNC_SLL), '0, '0, 0);
        run_txn({OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'h08}, '0, '0, 0);

        v = $urandom();
        run_txn(rtype_word(5'd5, 5'd6, 5'd7, 5'd0, FUNC_ADD),
                {1'b1, 5'd5, v}, {1'b1, 5'd5, ~v}, 0);
        run_txn(rtype_word(5'd5, 5'd6, 5'd8, 5'd0, FUNC_ADD), '0, {1'b1, 5'd6, v}, 0);
        run_txn(rtype_word(5'd0, 5'd4, 5'd9, 5'd0, FUNC_SUB),
                {1'b1, 5'd0, v}, {1'b1, 5'd0, ~v}, 0);
        run_txn(rtype_word(5'd5, 5'd6, 5'd10, 5'd0, FUNC_AND),
                {1'b0, 5'd5, v}, {1'b0, 5'd6, ~v}, 0);

        rs = rand_addr();
        run_txn(rtype_word(rs, 5'd11, 5'd12, 5'd0, FUNC_XOR), '0, '0, 4); // back-pressure

        write_reg(5'd0, $urandom());
        run_txn(rtype_word(5'd0, 5'd0, 5'd7, 5'd0, FUNC_OR), '0, '0, 0);

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected results were never compared", exp_q.size());
            errors++;
        end
        $display("errors: %0d  transactions: %0d", errors, txn_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_i,
    input  word_t       inst_i,
    input  reg_write_t  ex_fwd_i,
    input  reg_write_t  mem_fwd_i,
    input  reg_write_t  wb_i,
    output logic        ack_o,
    output decode_out_t result_o
);

    decode_ctrl_t ctrl;
    reg_addr_t    rs;
    reg_addr_t    rt;
    word_t        rdata1;
    word_t        rdata2;
    word_t        reg1;
    word_t        reg2;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .ctrl_o (ctrl),
        .rs_o   (rs),
        .rt_o   (rt)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wr_i     (wb_i)
    );

    // operand 1 from rs
    operand_select u_op1 (
        .read_en_i  (ctrl.reg1_read),
        .addr_i     (rs),
        .reg_data_i (rdata1),
        .imm_i      (ctrl.imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (reg1)
    );

    // operand 2 from rt
    operand_select u_op2 (
        .read_en_i  (ctrl.reg2_read),
        .addr_i     (rt),
        .reg_data_i (rdata2),
        .imm_i      (ctrl.imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (reg2)
    );

    decode_handshake u_hs (
        .clk      (clk),
        .rst      (rst),
        .req_i    (req_i),
        .ack_o    (ack_o),
        .ctrl_i   (ctrl),
        .reg1_i   (reg1),
        .reg2_i   (reg2),
        .result_o (result_o)
    );

endmodule

/* decode_handshake.sv */
`timescale 1ns/1ns

module decode_handshake import decode_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         req_i,
    output logic         ack_o,
    input  decode_ctrl_t ctrl_i,
    input  word_t        reg1_i,
    input  word_t        reg2_i,
    output decode_out_t  result_o
);

    logic        ack_q;
    decode_out_t result_q;
    decode_out_t result_d;

    always_comb begin
        result_d.aluop      = ctrl_i.aluop;
        result_d.alusel     = ctrl_i.alusel;
        result_d.wd         = ctrl_i.wd;
        result_d.wreg       = ctrl_i.wreg;
        result_d.inst_valid = ctrl_i.inst_valid;
        result_d.reg1       = reg1_i;
        result_d.reg2       = reg2_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            result_q <= '0;
        end else if (req_i && !ack_q) begin
            ack_q    <= 1'b1; // latch and acknowledge
            result_q <= result_d;
        end else if (!req_i && ack_q) begin
            ack_q <= 1'b0; // return to idle
        end
    end

    assign ack_o    = ack_q;
    assign result_o = result_q;

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack_q) |-> $past(req_i))
        else $error("ack rose without req");

    // result must not move until the next handshake
    a_result_held: assert property (
        @(posedge clk) disable iff (rst) (ack_q && $past(ack_q)) |-> $stable(result_q))
        else $error("result changed while ack high");

endmodule

/* operand_select.sv */
`timescale 1ns/1ns

module operand_select import decode_pkg::*; (
    input  logic       read_en_i,
    input  reg_addr_t  addr_i,
    input  word_t      reg_data_i,
    input  word_t      imm_i,
    input  reg_write_t ex_fwd_i,
    input  reg_write_t mem_fwd_i,
    output word_t      operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.wreg  && ex_fwd_i.wd  == addr_i && ex_fwd_i.wd  != '0;
    assign mem_hit = mem_fwd_i.wreg && mem_fwd_i.wd == addr_i && mem_fwd_i.wd != '0;

    always_comb begin
        if (!read_en_i) operand_o = imm_i;
        else if (ex_hit) operand_o = ex_fwd_i.wdata; // ex is youngest
        else if (mem_hit) operand_o = mem_fwd_i.wdata;
        else operand_o = reg_data_i;
    end

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder import decode_pkg::*; (
    input  word_t        inst_i,
    output decode_ctrl_t ctrl_o,
    output reg_addr_t    rs_o,
    output reg_addr_t    rt_o
);

    logic [5:0]  opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [5:0]  func;
    logic [15:0] imm16;
    word_t       imm_zext;
    word_t       imm_sext;

    assign {opcode, rs, rt, rd, sa, func} = inst_i;
    assign imm16    = inst_i[15:0];
    assign imm_zext = {16'h0000, imm16};
    assign imm_sext = {{16{imm16[15]}}, imm16};

    // read addresses always come straight from the fields
    assign rs_o = rs;
    assign rt_o = rt;

    // three-register form, rd written
    function automatic decode_ctrl_t rr_form(alu_op_e op, alu_sel_e sel, reg_addr_t dst);
        decode_ctrl_t c;
        c            = '0;
        c.aluop      = op;
        c.alusel     = sel;
        c.wd         = dst;
        c.wreg       = 1'b1;
        c.reg1_read  = 1'b1;
        c.reg2_read  = 1'b1;
        c.inst_valid = 1'b1;
        return c;
    endfunction

    // shift by sa, only rt read
    function automatic decode_ctrl_t sh_form(alu_op_e op, reg_addr_t dst, logic [4:0] shamt);
        decode_ctrl_t c;
        c            = '0;
        c.aluop      = op;
        c.alusel     = SEL_SHIFT;
        c.wd         = dst;
        c.wreg       = 1'b1;
        c.reg2_read  = 1'b1;
        c.imm        = {27'd0, shamt}; // sa rides in imm
        c.inst_valid = 1'b1;
        return c;
    endfunction

    // immediate form, rs read, rt written
    function automatic decode_ctrl_t ri_form(alu_op_e op, alu_sel_e sel, reg_addr_t dst,
                                             word_t imm);
        decode_ctrl_t c;
        c            = '0;
        c.aluop      = op;
        c.alusel     = sel;
        c.wd         = dst;
        c.wreg       = 1'b1;
        c.reg1_read  = 1'b1;
        c.imm        = imm;
        c.inst_valid = 1'b1;
        return c;
    endfunction

    always_comb begin
        ctrl_o        = '0; // invalid unless matched below
        ctrl_o.aluop  = ALU_NOP;
        ctrl_o.alusel = SEL_NOP;
        ctrl_o.wd     = rd;
        case (opcode_e'(opcode))
            OP_SPECIAL: begin
                case (func_e'(func))
                    FUNC_AND:  if (sa == '0) ctrl_o = rr_form(ALU_AND, SEL_LOGIC, rd);
                    FUNC_OR:   if (sa == '0) ctrl_o = rr_form(ALU_OR,  SEL_LOGIC, rd);
                    FUNC_XOR:  if (sa == '0) ctrl_o = rr_form(ALU_XOR, SEL_LOGIC, rd);
                    FUNC_NOR:  if (sa == '0) ctrl_o = rr_form(ALU_NOR, SEL_LOGIC, rd);
                    FUNC_SLLV: if (sa == '0) ctrl_o = rr_form(ALU_SLL, SEL_SHIFT, rd);
                    FUNC_SRLV: if (sa == '0) ctrl_o = rr_form(ALU_SRL, SEL_SHIFT, rd);
                    FUNC_SRAV: if (sa == '0) ctrl_o = rr_form(ALU_SRA, SEL_SHIFT, rd);
                    FUNC_SLL:  if (rs == '0) ctrl_o = sh_form(ALU_SLL, rd, sa);
                    FUNC_SRL:  if (rs == '0) ctrl_o = sh_form(ALU_SRL, rd, sa);
                    FUNC_SRA:  if (rs == '0) ctrl_o = sh_form(ALU_SRA, rd, sa);
                    // arithmetic has no sa check
                    FUNC_ADD:  ctrl_o = rr_form(ALU_ADD,  SEL_ARITH, rd);
                    FUNC_ADDU: ctrl_o = rr_form(ALU_ADDU, SEL_ARITH, rd);
                    FUNC_SUB:  ctrl_o = rr_form(ALU_SUB,  SEL_ARITH, rd);
                    FUNC_SUBU: ctrl_o = rr_form(ALU_SUBU, SEL_ARITH, rd);
                    FUNC_SLT:  ctrl_o = rr_form(ALU_SLT,  SEL_ARITH, rd);
                    FUNC_SLTU: ctrl_o = rr_form(ALU_SLTU, SEL_ARITH, rd);
                    default: ;
                endcase
            end
            OP_ANDI:  ctrl_o = ri_form(ALU_ANDI,  SEL_LOGIC, rt, imm_zext);
            OP_ORI:   ctrl_o = ri_form(ALU_ORI,   SEL_LOGIC, rt, imm_zext);
            OP_XORI:  ctrl_o = ri_form(ALU_XORI,  SEL_LOGIC, rt, imm_zext);
            OP_LUI:   ctrl_o = ri_form(ALU_LUI,   SEL_LOGIC, rt, {imm16, 16'h0000}); // rs still read
            OP_ADDI:  ctrl_o = ri_form(ALU_ADDI,  SEL_ARITH, rt, imm_sext);
            OP_ADDIU: ctrl_o = ri_form(ALU_ADDIU, SEL_ARITH, rt, imm_sext);
            OP_SLTI:  ctrl_o = ri_form(ALU_SLTI,  SEL_ARITH, rt, imm_sext);
            OP_SLTIU: ctrl_o = ri_form(ALU_SLTIU, SEL_ARITH, rt, imm_sext);
            default: ;
        endcase
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ns

module reg_file import decode_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_addr_t  raddr1_i,
    input  reg_addr_t  raddr2_i,
    output word_t      rdata1_o,
    output word_t      rdata2_o,
    input  reg_write_t wr_i
);

    word_t regs [1:31]; // $0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wreg && wr_i.wd != '0) begin
            regs[wr_i.wd] <= wr_i.wdata;
        end
    end

    // no write-to-read bypass, same-cycle read sees old value
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // special function field, inst[5:0]
    typedef enum logic [5:0] {
        FUNC_SLL  = 6'b000000,
        FUNC_SRL  = 6'b000010,
        FUNC_SRA  = 6'b000011,
        FUNC_SLLV = 6'b000100,
        FUNC_SRLV = 6'b000110,
        FUNC_SRAV = 6'b000111,
        FUNC_ADD  = 6'b100000,
        FUNC_ADDU = 6'b100001,
        FUNC_SUB  = 6'b100010,
        FUNC_SUBU = 6'b100011,
        FUNC_AND  = 6'b100100,
        FUNC_OR   = 6'b100101,
        FUNC_XOR  = 6'b100110,
        FUNC_NOR  = 6'b100111,
        FUNC_SLT  = 6'b101010,
        FUNC_SLTU = 6'b101011
    } func_e;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'h00,
        ALU_SRL   = 8'h02,
        ALU_SRA   = 8'h03,
        ALU_ADD   = 8'h20,
        ALU_ADDU  = 8'h21,
        ALU_SUB   = 8'h22,
        ALU_SUBU  = 8'h23,
        ALU_AND   = 8'h24,
        ALU_OR    = 8'h25,
        ALU_XOR   = 8'h26,
        ALU_NOR   = 8'h27,
        ALU_SLT   = 8'h2a,
        ALU_SLTU  = 8'h2b,
        ALU_ADDI  = 8'h55,
        ALU_ADDIU = 8'h56,
        ALU_SLTI  = 8'h57,
        ALU_SLTIU = 8'h58,
        ALU_ANDI  = 8'h59,
        ALU_ORI   = 8'h5a,
        ALU_XORI  = 8'h5b,
        ALU_LUI   = 8'h5c,
        ALU_SLL   = 8'h7c  // sll and sllv both
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alu_sel_e;

    // ex/mem bypass and writeback port
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } reg_write_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      reg1_read;
        logic      reg2_read;
        word_t     imm;
        logic      inst_valid;
    } decode_ctrl_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      inst_valid;
        word_t     reg1;
        word_t     reg2;
    } decode_out_t;

endpackage
